//--- hw/ex_settings.svh
`ifndef EX_SETTINGS_SVH
`define EX_SETTINGS_SVH

// Data and address width of the integer datapath
`define EX_XLEN 32

// Register file address width
`define EX_REG_ADDR_W 5

// Shift amount comes from the low bits of the second operand
`define EX_SHAMT_W 5

// Size of one instruction, used for the link address
`define EX_INSN_BYTES 32'd4

// Inactive values on reset and for suppressed results
`define EX_ZERO_WORD {`EX_XLEN{1'b0}}
`define EX_ZERO_ADDR {`EX_REG_ADDR_W{1'b0}}

`endif

//--- hw/ex_pkg.sv
package ex_pkg;

	// Operation code delivered by decode
	typedef enum logic [5:0]
	{
		OP_NOP,
		OP_OR,
		OP_XOR,
		OP_AND,
		OP_SLL,
		OP_SRL,
		OP_SRA,
		OP_ADD,
		OP_SUB,
		OP_SLT,
		OP_SLTU,
		OP_AUIPC,
		OP_JAL,
		OP_JALR,
		OP_BEQ,
		OP_BNE,
		OP_BLT,
		OP_BGE,
		OP_BLTU,
		OP_BGEU,
		OP_LB,
		OP_LH,
		OP_LW,
		OP_LBU,
		OP_LHU,
		OP_SB,
		OP_SH,
		OP_SW
	} alu_op_e;

	// Source of the write-back word
	typedef enum logic [2:0]
	{
		SEL_NONE,
		SEL_LOGIC,
		SEL_SHIFT,
		SEL_ARITH,
		SEL_LINK,
		SEL_STORE
	} res_sel_e;

	// Operation handed over to the memory stage
	typedef enum logic [3:0]
	{
		MEM_NOP,
		MEM_LB,
		MEM_LH,
		MEM_LW,
		MEM_LBU,
		MEM_LHU,
		MEM_SB,
		MEM_SH,
		MEM_SW
	} mem_op_e;

endpackage

//--- hw/ex_alu.sv
`include "ex_settings.svh"

module ex_alu
(
	input  ex_pkg::alu_op_e       alu_op_i,
	input  logic [`EX_XLEN-1:0]   rs1_data_i,
	input  logic [`EX_XLEN-1:0]   rs2_data_i,
	input  logic [`EX_XLEN-1:0]   pc_i,
	input  logic [`EX_XLEN-1:0]   offset_i,
	output logic [`EX_XLEN-1:0]   logic_res_o,
	output logic [`EX_XLEN-1:0]   shift_res_o,
	output logic [`EX_XLEN-1:0]   arith_res_o
);

	logic                      is_sub;
	logic [`EX_XLEN-1:0]       adder_b;
	logic [`EX_XLEN-1:0]       sum;
	logic                      lt_signed;
	logic                      lt_unsigned;
	logic [`EX_SHAMT_W-1:0]    shamt;

	// One adder serves ADD and SUB, two's complement of rs2 for SUB
	assign is_sub  = (alu_op_i == ex_pkg::OP_SUB);
	assign adder_b = is_sub ? ~rs2_data_i : rs2_data_i;
	assign sum     = rs1_data_i + adder_b + {{(`EX_XLEN-1){1'b0}}, is_sub};

	assign lt_signed   = ($signed(rs1_data_i) < $signed(rs2_data_i));
	assign lt_unsigned = (rs1_data_i < rs2_data_i);

	assign shamt = rs2_data_i[`EX_SHAMT_W-1:0];

	always_comb
	begin
		case (alu_op_i)
			ex_pkg::OP_OR:
				logic_res_o = rs1_data_i | rs2_data_i;
			ex_pkg::OP_XOR:
				logic_res_o = rs1_data_i ^ rs2_data_i;
			ex_pkg::OP_AND:
				logic_res_o = rs1_data_i & rs2_data_i;
			default:
				logic_res_o = `EX_ZERO_WORD;
		endcase
	end

	always_comb
	begin
		case (alu_op_i)
			ex_pkg::OP_SLL:
				shift_res_o = rs1_data_i << shamt;
			ex_pkg::OP_SRL:
				shift_res_o = rs1_data_i >> shamt;
			// Arithmetic shift keeps the sign of rs1
			ex_pkg::OP_SRA:
				shift_res_o = $signed(rs1_data_i) >>> shamt;
			default:
				shift_res_o = `EX_ZERO_WORD;
		endcase
	end

	always_comb
	begin
		case (alu_op_i)
			ex_pkg::OP_ADD, ex_pkg::OP_SUB:
				arith_res_o = sum;
			ex_pkg::OP_SLT:
				arith_res_o = {{(`EX_XLEN-1){1'b0}}, lt_signed};
			ex_pkg::OP_SLTU:
				arith_res_o = {{(`EX_XLEN-1){1'b0}}, lt_unsigned};
			ex_pkg::OP_AUIPC:
				arith_res_o = pc_i + offset_i;
			default:
				arith_res_o = `EX_ZERO_WORD;
		endcase
	end

endmodule

//--- hw/ex_branch_unit.sv
`include "ex_settings.svh"

module ex_branch_unit
(
	input  ex_pkg::alu_op_e       alu_op_i,
	input  logic [`EX_XLEN-1:0]   pc_i,
	input  logic [`EX_XLEN-1:0]   rs1_data_i,
	input  logic [`EX_XLEN-1:0]   rs2_data_i,
	input  logic [`EX_XLEN-1:0]   offset_i,
	output logic [`EX_XLEN-1:0]   link_addr_o,
	output logic                  taken_o,
	output logic [`EX_XLEN-1:0]   target_o,
	output ex_pkg::mem_op_e       mem_op_o,
	output logic [`EX_XLEN-1:0]   mem_addr_o,
	output logic                  is_load_o
);

	logic                  use_signed;
	logic                  eq;
	logic                  lt;
	logic [`EX_XLEN-1:0]   pc_rel;
	logic [`EX_XLEN-1:0]   rs1_rel;

	// BLT and BGE compare signed, the unsigned variants do not
	assign use_signed = (alu_op_i == ex_pkg::OP_BLT) || (alu_op_i == ex_pkg::OP_BGE);
	assign eq = (rs1_data_i == rs2_data_i);
	assign lt = use_signed ? ($signed(rs1_data_i) < $signed(rs2_data_i))
	                       : (rs1_data_i < rs2_data_i);

	assign pc_rel  = pc_i + offset_i;
	// Shared by JALR and the load/store effective address
	assign rs1_rel = rs1_data_i + offset_i;

	assign mem_addr_o = rs1_rel;

	always_comb
	begin
		taken_o     = 1'b0;
		target_o    = `EX_ZERO_WORD;
		link_addr_o = `EX_ZERO_WORD;
		case (alu_op_i)
			// JAL was already redirected in decode, only the link is left
			ex_pkg::OP_JAL:
				link_addr_o = pc_i + `EX_INSN_BYTES;
			ex_pkg::OP_JALR:
			begin
				taken_o     = 1'b1;
				target_o    = {rs1_rel[`EX_XLEN-1:1], 1'b0};
				link_addr_o = pc_i + `EX_INSN_BYTES;
			end
			ex_pkg::OP_BEQ:
			begin
				taken_o  = eq;
				target_o = pc_rel;
			end
			ex_pkg::OP_BNE:
			begin
				taken_o  = ~eq;
				target_o = pc_rel;
			end
			ex_pkg::OP_BLT, ex_pkg::OP_BLTU:
			begin
				taken_o  = lt;
				target_o = pc_rel;
			end
			ex_pkg::OP_BGE, ex_pkg::OP_BGEU:
			begin
				taken_o  = ~lt;
				target_o = pc_rel;
			end
			default:
				taken_o = 1'b0;
		endcase
	end

	always_comb
	begin
		is_load_o = 1'b0;
		case (alu_op_i)
			ex_pkg::OP_LB:
			begin
				mem_op_o  = ex_pkg::MEM_LB;
				is_load_o = 1'b1;
			end
			ex_pkg::OP_LH:
			begin
				mem_op_o  = ex_pkg::MEM_LH;
				is_load_o = 1'b1;
			end
			ex_pkg::OP_LW:
			begin
				mem_op_o  = ex_pkg::MEM_LW;
				is_load_o = 1'b1;
			end
			ex_pkg::OP_LBU:
			begin
				mem_op_o  = ex_pkg::MEM_LBU;
				is_load_o = 1'b1;
			end
			ex_pkg::OP_LHU:
			begin
				mem_op_o  = ex_pkg::MEM_LHU;
				is_load_o = 1'b1;
			end
			ex_pkg::OP_SB:
				mem_op_o = ex_pkg::MEM_SB;
			ex_pkg::OP_SH:
				mem_op_o = ex_pkg::MEM_SH;
			ex_pkg::OP_SW:
				mem_op_o = ex_pkg::MEM_SW;
			default:
				mem_op_o = ex_pkg::MEM_NOP;
		endcase
	end

endmodule

//--- hw/ex_result_stage.sv
`include "ex_settings.svh"

module ex_result_stage
(
	input  logic                        clk,
	input  logic                        rst,
	input  ex_pkg::res_sel_e            res_sel_i,
	input  logic                        wr_en_i,
	input  logic [`EX_REG_ADDR_W-1:0]   wr_addr_i,
	input  logic [`EX_XLEN-1:0]         logic_res_i,
	input  logic [`EX_XLEN-1:0]         shift_res_i,
	input  logic [`EX_XLEN-1:0]         arith_res_i,
	input  logic [`EX_XLEN-1:0]         link_addr_i,
	input  logic [`EX_XLEN-1:0]         store_data_i,
	input  logic                        taken_i,
	input  logic [`EX_XLEN-1:0]         target_i,
	input  ex_pkg::mem_op_e             mem_op_i,
	input  logic [`EX_XLEN-1:0]         mem_addr_i,
	input  logic                        is_load_i,
	output logic                        wr_en_o,
	output logic [`EX_REG_ADDR_W-1:0]   wr_addr_o,
	output logic [`EX_XLEN-1:0]         wr_data_o,
	output logic                        branch_taken_o,
	output logic [`EX_XLEN-1:0]         branch_target_o,
	output ex_pkg::mem_op_e             mem_op_o,
	output logic [`EX_XLEN-1:0]         mem_addr_o,
	output logic                        is_load_o
);

	logic                  to_x0;
	logic [`EX_XLEN-1:0]   sel_data;

	// x0 is hardwired to zero, so a write to it is dropped entirely
	assign to_x0 = wr_en_i && (wr_addr_i == `EX_ZERO_ADDR);

	always_comb
	begin
		case (res_sel_i)
			ex_pkg::SEL_LOGIC:
				sel_data = logic_res_i;
			ex_pkg::SEL_SHIFT:
				sel_data = shift_res_i;
			ex_pkg::SEL_ARITH:
				sel_data = arith_res_i;
			ex_pkg::SEL_LINK:
				sel_data = link_addr_i;
			// Store data rides on the write-back bus
			ex_pkg::SEL_STORE:
				sel_data = store_data_i;
			default:
				sel_data = `EX_ZERO_WORD;
		endcase
	end

	// EX/MEM pipeline register
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wr_en_o         <= 1'b0;
			wr_addr_o       <= `EX_ZERO_ADDR;
			wr_data_o       <= `EX_ZERO_WORD;
			branch_taken_o  <= 1'b0;
			branch_target_o <= `EX_ZERO_WORD;
			mem_op_o        <= ex_pkg::MEM_NOP;
			mem_addr_o      <= `EX_ZERO_WORD;
			is_load_o       <= 1'b0;
		end
		else
		begin
			wr_en_o         <= to_x0 ? 1'b0 : wr_en_i;
			wr_addr_o       <= to_x0 ? `EX_ZERO_ADDR : wr_addr_i;
			wr_data_o       <= to_x0 ? `EX_ZERO_WORD : sel_data;
			branch_taken_o  <= taken_i;
			branch_target_o <= target_i;
			mem_op_o        <= mem_op_i;
			mem_addr_o      <= mem_addr_i;
			is_load_o       <= is_load_i;
		end
	end

endmodule

//--- hw/ex_stage.sv
`include "ex_settings.svh"

module ex_stage
(
	input  logic                        clk,
	input  logic                        rst,
	input  logic [`EX_XLEN-1:0]         pc_i,
	input  ex_pkg::alu_op_e             alu_op_i,
	input  ex_pkg::res_sel_e            res_sel_i,
	input  logic [`EX_XLEN-1:0]         rs1_data_i,
	input  logic [`EX_XLEN-1:0]         rs2_data_i,
	input  logic [`EX_XLEN-1:0]         offset_i,
	input  logic                        wr_en_i,
	input  logic [`EX_REG_ADDR_W-1:0]   wr_addr_i,
	output logic                        wr_en_o,
	output logic [`EX_REG_ADDR_W-1:0]   wr_addr_o,
	output logic [`EX_XLEN-1:0]         wr_data_o,
	output logic                        branch_taken_o,
	output logic [`EX_XLEN-1:0]         branch_target_o,
	output ex_pkg::mem_op_e             mem_op_o,
	output logic [`EX_XLEN-1:0]         mem_addr_o,
	output logic                        is_load_o
);

	logic [`EX_XLEN-1:0]   logic_res;
	logic [`EX_XLEN-1:0]   shift_res;
	logic [`EX_XLEN-1:0]   arith_res;
	logic [`EX_XLEN-1:0]   link_addr;
	logic                  taken;
	logic [`EX_XLEN-1:0]   target;
	ex_pkg::mem_op_e       mem_op;
	logic [`EX_XLEN-1:0]   mem_addr;
	logic                  is_load;

	ex_alu u_alu
	(
		.alu_op_i    (alu_op_i),
		.rs1_data_i  (rs1_data_i),
		.rs2_data_i  (rs2_data_i),
		.pc_i        (pc_i),
		.offset_i    (offset_i),
		.logic_res_o (logic_res),
		.shift_res_o (shift_res),
		.arith_res_o (arith_res)
	);

	ex_branch_unit u_branch_unit
	(
		.alu_op_i    (alu_op_i),
		.pc_i        (pc_i),
		.rs1_data_i  (rs1_data_i),
		.rs2_data_i  (rs2_data_i),
		.offset_i    (offset_i),
		.link_addr_o (link_addr),
		.taken_o     (taken),
		.target_o    (target),
		.mem_op_o    (mem_op),
		.mem_addr_o  (mem_addr),
		.is_load_o   (is_load)
	);

	// rs2 doubles as the store data
	ex_result_stage u_result_stage
	(
		.clk             (clk),
		.rst             (rst),
		.res_sel_i       (res_sel_i),
		.wr_en_i         (wr_en_i),
		.wr_addr_i       (wr_addr_i),
		.logic_res_i     (logic_res),
		.shift_res_i     (shift_res),
		.arith_res_i     (arith_res),
		.link_addr_i     (link_addr),
		.store_data_i    (rs2_data_i),
		.taken_i         (taken),
		.target_i        (target),
		.mem_op_i        (mem_op),
		.mem_addr_i      (mem_addr),
		.is_load_i       (is_load),
		.wr_en_o         (wr_en_o),
		.wr_addr_o       (wr_addr_o),
		.wr_data_o       (wr_data_o),
		.branch_taken_o  (branch_taken_o),
		.branch_target_o (branch_target_o),
		.mem_op_o        (mem_op_o),
		.mem_addr_o      (mem_addr_o),
		.is_load_o       (is_load_o)
	);

endmodule

//--- verification/tb_ex_stage_tasks.svh
`ifndef TB_EX_STAGE_TASKS_SVH
`define TB_EX_STAGE_TASKS_SVH

// Expected EX/MEM record for the operation under check
logic                        exp_wr_en;
logic [`EX_REG_ADDR_W-1:0]   exp_wr_addr;
logic [`EX_XLEN-1:0]         exp_wr_data;
logic                        exp_taken;
logic [`EX_XLEN-1:0]         exp_target;
ex_pkg::mem_op_e             exp_mem_op;
logic [`EX_XLEN-1:0]         exp_mem_addr;
logic                        exp_is_load;

function automatic logic [`EX_XLEN-1:0] rand_word();
	return $random(seed);
endfunction

function automatic logic [`EX_REG_ADDR_W-1:0] rand_reg();
	logic [`EX_XLEN-1:0] word;
	word = rand_word();
	// Register 0 is left to the suppression test
	if (word[`EX_REG_ADDR_W-1:0] == 5'd0)
		return 5'd1;
	return word[`EX_REG_ADDR_W-1:0];
endfunction

// Reference model of one operation
task automatic predict(
	input ex_pkg::alu_op_e             op,
	input ex_pkg::res_sel_e            sel,
	input logic [`EX_XLEN-1:0]         a,
	input logic [`EX_XLEN-1:0]         b,
	input logic [`EX_XLEN-1:0]         pc_val,
	input logic [`EX_XLEN-1:0]         off,
	input logic                        en,
	input logic [`EX_REG_ADDR_W-1:0]   addr
);
	logic [`EX_XLEN-1:0]      data;
	logic [`EX_XLEN-1:0]      sra;
	logic [`EX_SHAMT_W-1:0]   sh;
	logic                     slt;
	logic                     sltu;
	sh   = b[`EX_SHAMT_W-1:0];
	slt  = ($signed(a) < $signed(b));
	sltu = (a < b);
	// Vacated upper bits take a copy of bit 31
	sra  = (a >> sh) | (a[`EX_XLEN-1] ? ~(32'hffff_ffff >> sh) : 32'h0);
	data = `EX_ZERO_WORD;
	case (sel)
		ex_pkg::SEL_LOGIC:
			data = (op == ex_pkg::OP_OR)  ? (a | b) :
			       (op == ex_pkg::OP_XOR) ? (a ^ b) :
			       (op == ex_pkg::OP_AND) ? (a & b) : `EX_ZERO_WORD;
		ex_pkg::SEL_SHIFT:
			data = (op == ex_pkg::OP_SLL) ? (a << sh) :
			       (op == ex_pkg::OP_SRL) ? (a >> sh) :
			       (op == ex_pkg::OP_SRA) ? sra : `EX_ZERO_WORD;
		ex_pkg::SEL_ARITH:
			case (op)
				ex_pkg::OP_ADD:   data = a + b;
				ex_pkg::OP_SUB:   data = a - b;
				ex_pkg::OP_SLT:   data = slt ? 32'd1 : 32'd0;
				ex_pkg::OP_SLTU:  data = sltu ? 32'd1 : 32'd0;
				ex_pkg::OP_AUIPC: data = pc_val + off;
				default:          data = `EX_ZERO_WORD;
			endcase
		ex_pkg::SEL_LINK:
			if (op == ex_pkg::OP_JAL || op == ex_pkg::OP_JALR)
				data = pc_val + 32'd4;
		ex_pkg::SEL_STORE:
			data = b;
		default:
			data = `EX_ZERO_WORD;
	endcase

	// A write to x0 is dropped completely
	exp_wr_en   = (en && addr == 5'd0) ? 1'b0 : en;
	exp_wr_addr = (en && addr == 5'd0) ? 5'd0 : addr;
	exp_wr_data = (en && addr == 5'd0) ? `EX_ZERO_WORD : data;

	case (op)
		ex_pkg::OP_BEQ:  exp_taken = (a == b);
		ex_pkg::OP_BNE:  exp_taken = (a != b);
		ex_pkg::OP_BLT:  exp_taken = slt;
		ex_pkg::OP_BGE:  exp_taken = !slt;
		ex_pkg::OP_BLTU: exp_taken = sltu;
		ex_pkg::OP_BGEU: exp_taken = !sltu;
		ex_pkg::OP_JALR: exp_taken = 1'b1;
		default:         exp_taken = 1'b0;
	endcase
	exp_target = `EX_ZERO_WORD;
	if (op inside {ex_pkg::OP_BEQ, ex_pkg::OP_BNE, ex_pkg::OP_BLT,
	               ex_pkg::OP_BGE, ex_pkg::OP_BLTU, ex_pkg::OP_BGEU})
		exp_target = pc_val + off;
	if (op == ex_pkg::OP_JALR)
		exp_target = (a + off) & ~32'h1;

	case (op)
		ex_pkg::OP_LB:  exp_mem_op = ex_pkg::MEM_LB;
		ex_pkg::OP_LH:  exp_mem_op = ex_pkg::MEM_LH;
		ex_pkg::OP_LW:  exp_mem_op = ex_pkg::MEM_LW;
		ex_pkg::OP_LBU: exp_mem_op = ex_pkg::MEM_LBU;
		ex_pkg::OP_LHU: exp_mem_op = ex_pkg::MEM_LHU;
		ex_pkg::OP_SB:  exp_mem_op = ex_pkg::MEM_SB;
		ex_pkg::OP_SH:  exp_mem_op = ex_pkg::MEM_SH;
		ex_pkg::OP_SW:  exp_mem_op = ex_pkg::MEM_SW;
		default:        exp_mem_op = ex_pkg::MEM_NOP;
	endcase
	exp_is_load  = op inside {ex_pkg::OP_LB, ex_pkg::OP_LH, ex_pkg::OP_LW,
	                          ex_pkg::OP_LBU, ex_pkg::OP_LHU};
	exp_mem_addr = a + off;
endtask

task automatic check_value(
	input string                 name,
	input logic [`EX_XLEN-1:0]   actual,
	input logic [`EX_XLEN-1:0]   expected
);
	if (actual !== expected)
	begin
		$display("[FAIL] time %0t: %s is %h, expected %h", $time, name, actual, expected);
		$display("SOME TESTS FAILED");
		$fatal(1, "output mismatch");
	end
endtask

task automatic check_outputs();
	check_value("wr_en_o", 32'(wr_en_out), 32'(exp_wr_en));
	check_value("wr_addr_o", 32'(wr_addr_out), 32'(exp_wr_addr));
	check_value("wr_data_o", wr_data_out, exp_wr_data);
	check_value("branch_taken_o", 32'(taken_out), 32'(exp_taken));
	check_value("branch_target_o", target_out, exp_target);
	check_value("mem_op_o", 32'(mem_op_out), 32'(exp_mem_op));
	check_value("mem_addr_o", mem_addr_out, exp_mem_addr);
	check_value("is_load_o", 32'(is_load_out), 32'(exp_is_load));
endtask

task automatic drive_op(
	input ex_pkg::alu_op_e             op,
	input ex_pkg::res_sel_e            sel,
	input logic [`EX_XLEN-1:0]         a,
	input logic [`EX_XLEN-1:0]         b,
	input logic [`EX_XLEN-1:0]         pc_val,
	input logic [`EX_XLEN-1:0]         off,
	input logic                        en,
	input logic [`EX_REG_ADDR_W-1:0]   addr
);
	@(posedge clk);
	alu_op     <= op;
	res_sel    <= sel;
	rs1        <= a;
	rs2        <= b;
	pc         <= pc_val;
	offset     <= off;
	wr_en_in   <= en;
	wr_addr_in <= addr;
endtask

// Applies one operation and checks it after the capturing edge
task automatic run_op(
	input ex_pkg::alu_op_e             op,
	input ex_pkg::res_sel_e            sel,
	input logic [`EX_XLEN-1:0]         a,
	input logic [`EX_XLEN-1:0]         b,
	input logic [`EX_XLEN-1:0]         pc_val,
	input logic [`EX_XLEN-1:0]         off,
	input logic                        en,
	input logic [`EX_REG_ADDR_W-1:0]   addr
);
	drive_op(op, sel, a, b, pc_val, off, en, addr);
	@(posedge clk);
	@(negedge clk);
	predict(op, sel, a, b, pc_val, off, en, addr);
	check_outputs();
endtask

task automatic reset_and_latency();
	logic [`EX_XLEN-1:0] a;
	logic [`EX_XLEN-1:0] b;
	a = rand_word();
	b = rand_word();
	@(negedge clk);
	predict(ex_pkg::OP_NOP, ex_pkg::SEL_NONE, 32'h0, 32'h0, 32'h0, 32'h0, 1'b0, 5'd0);
	check_outputs();
	drive_op(ex_pkg::OP_ADD, ex_pkg::SEL_ARITH, a, b, 32'h0, 32'h0, 1'b1, 5'd7);
	// Not yet captured, outputs stay inactive
	@(negedge clk);
	check_outputs();
	@(posedge clk);
	@(negedge clk);
	predict(ex_pkg::OP_ADD, ex_pkg::SEL_ARITH, a, b, 32'h0, 32'h0, 1'b1, 5'd7);
	check_outputs();
endtask

task automatic logic_pair(input ex_pkg::alu_op_e op);
	run_op(op, ex_pkg::SEL_LOGIC, rand_word(), rand_word(), 32'h0, 32'h0, 1'b1, rand_reg());
	run_op(op, ex_pkg::SEL_LOGIC, rand_word(), rand_word(), 32'h0, 32'h0, 1'b1, rand_reg());
endtask

// Random amount, then 0 and 31 with random upper bits in rs2
task automatic shift_cases(input ex_pkg::alu_op_e op);
	logic [`EX_XLEN-1:0] a;
	a = rand_word();
	if (op == ex_pkg::OP_SRA)
		a = a | 32'h8000_0000;
	run_op(op, ex_pkg::SEL_SHIFT, a, rand_word(), 32'h0, 32'h0, 1'b1, rand_reg());
	run_op(op, ex_pkg::SEL_SHIFT, a, rand_word() & ~32'h1f, 32'h0, 32'h0, 1'b1, rand_reg());
	run_op(op, ex_pkg::SEL_SHIFT, a, rand_word() | 32'h1f, 32'h0, 32'h0, 1'b1, rand_reg());
endtask

task automatic logic_and_shift_ops();
	logic_pair(ex_pkg::OP_OR);
	logic_pair(ex_pkg::OP_XOR);
	logic_pair(ex_pkg::OP_AND);
	shift_cases(ex_pkg::OP_SLL);
	shift_cases(ex_pkg::OP_SRL);
	shift_cases(ex_pkg::OP_SRA);
endtask

task automatic arith_op(
	input ex_pkg::alu_op_e       op,
	input logic [`EX_XLEN-1:0]   a,
	input logic [`EX_XLEN-1:0]   b
);
	run_op(op, ex_pkg::SEL_ARITH, a, b, rand_word(), rand_word(), 1'b1, rand_reg());
endtask

task automatic arithmetic_ops();
	arith_op(ex_pkg::OP_ADD, 32'h7fff_ffff, 32'h0000_0001);
	arith_op(ex_pkg::OP_ADD, 32'hffff_ffff, 32'h0000_0002);
	arith_op(ex_pkg::OP_ADD, rand_word(), rand_word());
	arith_op(ex_pkg::OP_SUB, 32'h8000_0000, 32'h0000_0001);
	arith_op(ex_pkg::OP_SUB, 32'h0000_0000, 32'h0000_0001);
	arith_op(ex_pkg::OP_SUB, rand_word(), rand_word());
	// -5 against 3 gives opposite answers signed and unsigned
	arith_op(ex_pkg::OP_SLT, 32'hffff_fffb, 32'h0000_0003);
	arith_op(ex_pkg::OP_SLTU, 32'hffff_fffb, 32'h0000_0003);
	arith_op(ex_pkg::OP_SLT, 32'h0000_0003, 32'hffff_fffb);
	arith_op(ex_pkg::OP_SLTU, 32'h0000_0003, 32'hffff_fffb);
	arith_op(ex_pkg::OP_AUIPC, rand_word(), rand_word());
	arith_op(ex_pkg::OP_AUIPC, rand_word(), rand_word());
endtask

// Equal operands, then negative against positive in both orders
task automatic branch_cases(input ex_pkg::alu_op_e op);
	logic [`EX_XLEN-1:0] pos;
	logic [`EX_XLEN-1:0] neg;
	logic [`EX_XLEN-1:0] pc_val;
	logic [`EX_XLEN-1:0] off;
	pos    = rand_word() & 32'h7fff_ffff;
	neg    = rand_word() | 32'h8000_0000;
	pc_val = rand_word() & ~32'h3;
	off    = rand_word();
	run_op(op, ex_pkg::SEL_NONE, pos, pos, pc_val, off, 1'b0, 5'd0);
	run_op(op, ex_pkg::SEL_NONE, neg, pos, pc_val, off, 1'b0, 5'd0);
	run_op(op, ex_pkg::SEL_NONE, pos, neg, pc_val, off, 1'b0, 5'd0);
endtask

task automatic branches_and_jumps();
	logic [`EX_XLEN-1:0] pc_val;
	logic [`EX_XLEN-1:0] off;
	branch_cases(ex_pkg::OP_BEQ);
	branch_cases(ex_pkg::OP_BNE);
	branch_cases(ex_pkg::OP_BLT);
	branch_cases(ex_pkg::OP_BGE);
	branch_cases(ex_pkg::OP_BLTU);
	branch_cases(ex_pkg::OP_BGEU);
	pc_val = rand_word() & ~32'h3;
	off    = rand_word() & ~32'h1;
	run_op(ex_pkg::OP_JAL, ex_pkg::SEL_LINK, rand_word(), rand_word(), pc_val, off,
	       1'b1, rand_reg());
	// Even sum, then odd sum where bit 0 is cleared
	run_op(ex_pkg::OP_JALR, ex_pkg::SEL_LINK, rand_word() & ~32'h1, rand_word(), pc_val, off,
	       1'b1, rand_reg());
	run_op(ex_pkg::OP_JALR, ex_pkg::SEL_LINK, rand_word() | 32'h1, rand_word(), pc_val, off,
	       1'b1, rand_reg());
endtask

task automatic memory_case(input ex_pkg::alu_op_e op, input logic is_store);
	logic [`EX_XLEN-1:0] a;
	logic [`EX_XLEN-1:0] b;
	logic [`EX_XLEN-1:0] off;
	a   = rand_word();
	b   = rand_word();
	off = rand_word();
	if (is_store)
		run_op(op, ex_pkg::SEL_STORE, a, b, 32'h0, off, 1'b0, 5'd0);
	else
		run_op(op, ex_pkg::SEL_NONE, a, b, 32'h0, off, 1'b1, rand_reg());
endtask

task automatic memory_ops();
	memory_case(ex_pkg::OP_LB, 1'b0);
	memory_case(ex_pkg::OP_LH, 1'b0);
	memory_case(ex_pkg::OP_LW, 1'b0);
	memory_case(ex_pkg::OP_LBU, 1'b0);
	memory_case(ex_pkg::OP_LHU, 1'b0);
	memory_case(ex_pkg::OP_SB, 1'b1);
	memory_case(ex_pkg::OP_SH, 1'b1);
	memory_case(ex_pkg::OP_SW, 1'b1);
	// Not a memory opcode, so MEM_NOP
	memory_case(ex_pkg::OP_XOR, 1'b0);
endtask

task automatic x0_and_back_to_back();
	logic [`EX_XLEN-1:0] a0;
	logic [`EX_XLEN-1:0] b0;
	logic [`EX_XLEN-1:0] a1;
	logic [`EX_XLEN-1:0] b1;
	logic [`EX_XLEN-1:0] a2;
	logic [`EX_XLEN-1:0] b2;
	run_op(ex_pkg::OP_ADD, ex_pkg::SEL_ARITH, rand_word(), rand_word(), 32'h0, 32'h0,
	       1'b1, 5'd0);
	a0 = rand_word();
	b0 = rand_word();
	a1 = rand_word();
	b1 = rand_word();
	a2 = rand_word();
	b2 = rand_word();
	// A new operation every edge, each result one cycle later
	drive_op(ex_pkg::OP_ADD, ex_pkg::SEL_ARITH, a0, b0, 32'h0, 32'h0, 1'b1, 5'd1);
	drive_op(ex_pkg::OP_XOR, ex_pkg::SEL_LOGIC, a1, b1, 32'h0, 32'h0, 1'b1, 5'd2);
	@(negedge clk);
	predict(ex_pkg::OP_ADD, ex_pkg::SEL_ARITH, a0, b0, 32'h0, 32'h0, 1'b1, 5'd1);
	check_outputs();
	drive_op(ex_pkg::OP_SW, ex_pkg::SEL_STORE, a2, b2, 32'h0, 32'h10, 1'b0, 5'd0);
	@(negedge clk);
	predict(ex_pkg::OP_XOR, ex_pkg::SEL_LOGIC, a1, b1, 32'h0, 32'h0, 1'b1, 5'd2);
	check_outputs();
	drive_op(ex_pkg::OP_NOP, ex_pkg::SEL_NONE, 32'h0, 32'h0, 32'h0, 32'h0, 1'b0, 5'd0);
	@(negedge clk);
	predict(ex_pkg::OP_SW, ex_pkg::SEL_STORE, a2, b2, 32'h0, 32'h10, 1'b0, 5'd0);
	check_outputs();
endtask

`endif

//--- verification/tb_ex_stage.sv
`include "ex_settings.svh"

module tb_ex_stage;

	localparam int CLK_PERIOD   = 100;
	localparam int RESET_CYCLES = 3;
	// Upper bound on the operations issued by the test sequence
	localparam int OP_COUNT      = 70;
	localparam int WATCHDOG_TIME = (OP_COUNT + RESET_CYCLES) * 2 * CLK_PERIOD;

	logic                        clk;
	logic                        rst;
	logic [`EX_XLEN-1:0]         pc;
	ex_pkg::alu_op_e             alu_op;
	ex_pkg::res_sel_e            res_sel;
	logic [`EX_XLEN-1:0]         rs1;
	logic [`EX_XLEN-1:0]         rs2;
	logic [`EX_XLEN-1:0]         offset;
	logic                        wr_en_in;
	logic [`EX_REG_ADDR_W-1:0]   wr_addr_in;

	logic                        wr_en_out;
	logic [`EX_REG_ADDR_W-1:0]   wr_addr_out;
	logic [`EX_XLEN-1:0]         wr_data_out;
	logic                        taken_out;
	logic [`EX_XLEN-1:0]         target_out;
	ex_pkg::mem_op_e             mem_op_out;
	logic [`EX_XLEN-1:0]         mem_addr_out;
	logic                        is_load_out;

	integer seed;

	ex_stage UUT
	(
		.clk             (clk),
		.rst             (rst),
		.pc_i            (pc),
		.alu_op_i        (alu_op),
		.res_sel_i       (res_sel),
		.rs1_data_i      (rs1),
		.rs2_data_i      (rs2),
		.offset_i        (offset),
		.wr_en_i         (wr_en_in),
		.wr_addr_i       (wr_addr_in),
		.wr_en_o         (wr_en_out),
		.wr_addr_o       (wr_addr_out),
		.wr_data_o       (wr_data_out),
		.branch_taken_o  (taken_out),
		.branch_target_o (target_out),
		.mem_op_o        (mem_op_out),
		.mem_addr_o      (mem_addr_out),
		.is_load_o       (is_load_out)
	);

	`include "tb_ex_stage_tasks.svh"

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial
	begin
		#(WATCHDOG_TIME);
		$display("Timeout: the test sequence did not finish within %0d time units", WATCHDOG_TIME);
		$display("SOME TESTS FAILED");
		$fatal(1, "watchdog expired");
	end

	initial
	begin
		seed       = 32'h2962222b;
		rst        = 1'b1;
		// Only the reset keeps this live load off the outputs
		pc         = 32'h0000_1000;
		alu_op     = ex_pkg::OP_LW;
		res_sel    = ex_pkg::SEL_STORE;
		rs1        = 32'h0000_2000;
		rs2        = 32'h5a5a_a5a5;
		offset     = 32'h0000_0044;
		wr_en_in   = 1'b1;
		wr_addr_in = 5'd9;

		repeat (RESET_CYCLES) @(posedge clk);
		rst        <= 1'b0;
		pc         <= `EX_ZERO_WORD;
		alu_op     <= ex_pkg::OP_NOP;
		res_sel    <= ex_pkg::SEL_NONE;
		rs1        <= `EX_ZERO_WORD;
		rs2        <= `EX_ZERO_WORD;
		offset     <= `EX_ZERO_WORD;
		wr_en_in   <= 1'b0;
		wr_addr_in <= `EX_ZERO_ADDR;

		reset_and_latency();
		logic_and_shift_ops();
		arithmetic_ops();
		branches_and_jumps();
		memory_ops();
		x0_and_back_to_back();

		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

//--- ex_stage.f
+incdir+hw
+incdir+verification
hw/ex_pkg.sv
hw/ex_alu.sv
hw/ex_branch_unit.sv
hw/ex_result_stage.sv
hw/ex_stage.sv
verification/tb_ex_stage.sv

//--- run_sim.sh
#!/bin/sh
# Builds the execute stage with its testbench and runs it.
# The exit status is the simulator's: nonzero when the testbench reports failure.
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
	--top-module tb_ex_stage \
	-f ex_stage.f \
	-o sim_ex_stage

./obj_dir/sim_ex_stage
